// File: ca_rx_align.f
hw/ca_cfg_pkg.sv
hw/ca_ctrl_pkg.sv
hw/ca_stb_decode.sv
hw/ca_lane_deskew.sv
hw/ca_align_ctrl.sv
hw/ca_rx_align.sv
dv/ca_rx_align_sva.sv
dv/tb_ca_rx_align.sv

// File: run_sim.sh
#!/bin/sh
# Build the RX channel aligner testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_ca_rx_align -Mdir obj_dir -f ca_rx_align.f

./obj_dir/Vtb_ca_rx_align > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: dv/ca_rx_align_trace.txt
# rst rx_online rden_dly wd_sel bit_sel din_lane0 din_lane1, then expected dout_lane0
# dout_lane1 align_done align_err pos_err coding_err; one clock cycle per line, all hex
0 0 0 02 8000000000 0  0  0  0  0 0 0 0
0 0 0 04 0000000002 0  0  0  0  0 0 1 0
0 0 0 06 0000000010 0  0  0  0  0 0 0 1
0 0 0 01 0000000000 0  0  0  0  0 0 0 1
0 1 0 01 0000000010 1  2  0  0  0 0 0 0
0 1 0 01 0000000010 10 2  0  0  0 0 0 0
0 1 0 01 0000000010 11 2  0  0  0 0 0 0
0 1 0 01 0000000010 12 2  0  0  0 0 0 0
0 1 0 01 0000000010 13 30 0  0  0 0 0 0
0 1 0 01 0000000010 14 31 0  0  0 0 0 0
0 1 0 01 0000000010 15 32 10 30 1 0 0 0
0 1 0 01 0000000010 16 33 11 31 1 0 0 0
0 1 0 01 0000000010 17 34 12 32 1 0 0 0
1 0 0 01 0000000010 0  0  0  0  0 0 0 0
0 1 2 01 0000000010 1  2  0  0  0 0 0 0
0 1 2 01 0000000010 10 2  0  0  0 0 0 0
0 1 2 01 0000000010 11 2  0  0  0 0 0 0
0 1 2 01 0000000010 12 2  0  0  0 0 0 0
0 1 2 01 0000000010 13 30 0  0  0 0 0 0
0 1 2 01 0000000010 14 31 0  0  0 0 0 0
0 1 2 01 0000000010 15 32 0  0  0 0 0 0
0 1 2 01 0000000010 16 33 0  0  0 0 0 0
0 1 2 01 0000000010 17 34 10 30 1 0 0 0
0 1 2 01 0000000010 18 35 11 31 1 0 0 0
1 0 0 01 0000000010 0  0  0  0  0 0 0 0
0 1 0 01 0000000010 1  2  0  0  0 0 0 0
0 1 0 01 0000000010 10 2  0  0  0 0 0 0
0 1 0 01 0000000010 11 2  0  0  0 0 0 0
0 1 0 01 0000000010 12 2  0  0  0 0 0 0
0 1 0 01 0000000010 13 2  0  0  0 0 0 0
0 1 0 01 0000000010 14 2  0  0  0 0 0 0
0 1 0 01 0000000010 15 2  0  0  0 0 0 0
0 1 0 01 0000000010 16 2  0  0  0 0 0 0
0 1 0 01 0000000010 17 2  0  0  0 0 0 0
0 1 0 01 0000000010 18 2  0  0  0 0 0 0
0 1 0 01 0000000010 19 30 0  0  0 0 0 0
0 1 0 01 0000000010 1a 31 0  0  0 1 0 0
0 1 0 01 0000000010 1b 32 0  0  0 1 0 0

// File: dv/tb_ca_rx_align.sv
/*
  Testbench for the RX channel aligner.
  Replays dv/ca_rx_align_trace.txt, where each line holds the inputs of one
  clock cycle and the outputs expected in that cycle. Inputs change on the
  rising edge, outputs are checked on the falling edge.
*/
`default_nettype none

module tb_ca_rx_align;

  timeunit 1ns;
  timeprecision 100ps;

  import ca_cfg_pkg::*;

  localparam string TRACE_FILE     = "dv/ca_rx_align_trace.txt";
  localparam int    RST_CYCLES     = 3;
  localparam int    TIMEOUT_MARGIN = 20;

  // One trace line
  typedef struct packed {
    logic      rst;
    logic      online;
    rd_dly_t   dly;
    wd_sel_t   wd_sel;
    bit_sel_t  bit_sel;
    lane_bus_t din;
    lane_bus_t dout;      // Expected
    logic      done;
    logic      err;
    logic      pos_err;
    logic      coding_err;
  } trace_entry_t;

  logic      com_clk;
  logic      rst_com_n;
  logic      rx_online;
  rd_dly_t   rden_dly;
  wd_sel_t   rx_stb_wd_sel;
  bit_sel_t  rx_stb_bit_sel;
  lane_bus_t rx_din;
  lane_bus_t rx_dout;
  logic      align_done;
  logic      align_err;
  logic      rx_stb_pos_err;
  logic      rx_stb_pos_coding_err;

  trace_entry_t trace_q[$];
  int           line_idx    = 0;
  int           cycle_cnt   = 0;
  int           cycle_limit = 0;  // Set once the trace is loaded

  ca_rx_align i_ca_rx_align (.*);

  bind ca_align_ctrl ca_rx_align_sva i_align_sva (
    .com_clk    (com_clk),
    .rst_com_n  (rst_com_n),
    .lane_en    (lane_en),
    .fifo_pop   (fifo_pop),
    .align_done (align_done),
    .align_err  (align_err)
  );

  initial
  begin
    com_clk = 1'b0;
    forever #50 com_clk = ~com_clk;
  end

  //////////////////////////////
  // Trace handling
  task automatic load_trace();
    int           fd;
    int           n;
    string        line;
    logic         rst_f;
    logic         online_f;
    logic [2:0]   dly_f;
    logic [7:0]   wd_f;
    logic [39:0]  bit_f;
    logic [79:0]  din0;
    logic [79:0]  din1;
    logic [79:0]  dout0;
    logic [79:0]  dout1;
    logic         done_f;
    logic         err_f;
    logic         pos_f;
    logic         coding_f;
    trace_entry_t e;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open the trace file %s", TRACE_FILE);
      $display("TB FAILED");
      $fatal(1, "No stimulus available");
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#")   // Skip header and blank lines
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", rst_f, online_f,
                    dly_f, wd_f, bit_f, din0, din1, dout0, dout1, done_f, err_f,
                    pos_f, coding_f);
        if (n != 13)
        begin
          $display("Trace line has %0d fields instead of 13: %s", n, line);
          $display("TB FAILED");
          $fatal(1, "Bad trace format");
        end
        e.rst        = rst_f;
        e.online     = online_f;
        e.dly        = dly_f;
        e.wd_sel     = wd_f;
        e.bit_sel    = bit_f;
        e.din        = {din1, din0};  // Lane 0 in low bits
        e.dout       = {dout1, dout0};
        e.done       = done_f;
        e.err        = err_f;
        e.pos_err    = pos_f;
        e.coding_err = coding_f;
        trace_q.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_entry(input trace_entry_t e);
    rst_com_n      <= !e.rst;
    rx_online      <= e.online;
    rden_dly       <= e.dly;
    rx_stb_wd_sel  <= e.wd_sel;
    rx_stb_bit_sel <= e.bit_sel;
    rx_din         <= e.din;
  endtask

  task automatic check_value(input string name, input lane_bus_t got, input lane_bus_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s at trace line %0d: got 0x%0h, expected 0x%0h",
               name, line_idx, got, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_entry(input trace_entry_t e);
    check_value("rx_dout", rx_dout, e.dout);
    check_value("align_done", lane_bus_t'(align_done), lane_bus_t'(e.done));
    check_value("align_err", lane_bus_t'(align_err), lane_bus_t'(e.err));
    check_value("rx_stb_pos_err", lane_bus_t'(rx_stb_pos_err), lane_bus_t'(e.pos_err));
    check_value("rx_stb_pos_coding_err", lane_bus_t'(rx_stb_pos_coding_err),
                lane_bus_t'(e.coding_err));
    if (i_ca_rx_align.i_align_ctrl.i_align_sva.fail_cnt != 0)
    begin
      $display("A bound control assertion failed by trace line %0d", line_idx);
      $display("TB FAILED");
      $fatal(1, "Assertion failure");
    end
  endtask

  //////////////////////////////
  // Main sequence
  initial
  begin
    rst_com_n      = 1'b0;
    rx_online      = 1'b0;
    rden_dly       = '0;
    rx_stb_wd_sel  = '0;
    rx_stb_bit_sel = '0;
    rx_din         = '0;
    load_trace();
    cycle_limit = trace_q.size() + RST_CYCLES + TIMEOUT_MARGIN;
    repeat (RST_CYCLES) @(posedge com_clk);
    rst_com_n <= 1'b1;
    for (int i = 0; i < trace_q.size(); i++)
    begin
      line_idx = i + 1;
      @(posedge com_clk);
      apply_entry(trace_q[i]);
      @(negedge com_clk);           // Outputs settled mid cycle
      check_entry(trace_q[i]);
    end
    if (trace_q.size() > 0)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      $display("The trace file holds no cycles");
      $display("TB FAILED");
      $fatal(1, "Empty trace");
    end
  end

  // Timeout watchdog
  initial
  begin
    forever
    begin
      @(posedge com_clk);
      cycle_cnt++;
      if (cycle_limit != 0 && cycle_cnt > cycle_limit)
      begin
        $display("Timeout after %0d cycles, trace replay did not finish", cycle_cnt);
        $display("TB FAILED");
        $fatal(1, "Run exceeded the cycle limit");
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/ca_rx_align_sva.sv
/*
  Concurrent assertions on the alignment control outputs.
  Bound into ca_align_ctrl from the testbench.
*/
`default_nettype none

module ca_rx_align_sva
(
  input logic com_clk,
  input logic rst_com_n,
  input logic lane_en,
  input logic fifo_pop,
  input logic align_done,
  input logic align_err
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // Failed assertion count, polled by the testbench

  // Done and error are exclusive outcomes
  a_done_err_excl: assert property (@(posedge com_clk) disable iff (!rst_com_n)
    !(align_done && align_err))
    else
    begin
      $error("align_done and align_err are high together");
      fail_cnt++;
    end

  a_pop_needs_en: assert property (@(posedge com_clk) disable iff (!rst_com_n)
    fifo_pop |-> lane_en)
    else
    begin
      $error("fifo_pop is high while lane_en is low");
      fail_cnt++;
    end

  // Error held until reset
  a_err_sticky: assert property (@(posedge com_clk) disable iff (!rst_com_n)
    align_err |=> align_err)
    else
    begin
      $error("align_err dropped before reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: hw/ca_rx_align.sv
/*
  RX channel aligner top level.
  Decodes the strobe position, deskews the lanes against their
  strobe and reports alignment status. Single clock domain.
*/
`default_nettype none

module ca_rx_align
(
  input  logic                  com_clk,
  input  logic                  rst_com_n,
  input  logic                  rx_online,
  input  ca_cfg_pkg::rd_dly_t   rden_dly,
  input  ca_cfg_pkg::wd_sel_t   rx_stb_wd_sel,
  input  ca_cfg_pkg::bit_sel_t  rx_stb_bit_sel,
  input  ca_cfg_pkg::lane_bus_t rx_din,
  output ca_cfg_pkg::lane_bus_t rx_dout,
  output logic                  align_done,
  output logic                  align_err,
  output logic                  rx_stb_pos_err,
  output logic                  rx_stb_pos_coding_err
);

  import ca_ctrl_pkg::*;

  stb_pos_t   stb_pos;
  lane_stat_t lane_stat;
  logic       lane_en;
  logic       fifo_pop;

  ca_stb_decode i_stb_decode (
    .rx_stb_wd_sel         (rx_stb_wd_sel),
    .rx_stb_bit_sel        (rx_stb_bit_sel),
    .stb_pos               (stb_pos),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err)
  );

  ca_lane_deskew i_lane_deskew (
    .com_clk   (com_clk),
    .rst_com_n (rst_com_n),
    .rx_din    (rx_din),
    .stb_pos   (stb_pos),
    .lane_en   (lane_en),
    .fifo_pop  (fifo_pop),
    .lane_stat (lane_stat),
    .rx_dout   (rx_dout)
  );

  ca_align_ctrl i_align_ctrl (
    .com_clk    (com_clk),
    .rst_com_n  (rst_com_n),
    .rx_online  (rx_online),
    .rden_dly   (rden_dly),
    .lane_stat  (lane_stat),
    .lane_en    (lane_en),
    .fifo_pop   (fifo_pop),
    .align_done (align_done),
    .align_err  (align_err)
  );

endmodule

`default_nettype wire

// File: hw/ca_align_ctrl.sv
/*
  Alignment control.
  Runs the alignment FSM and the read delay counter, and decides when
  lanes write and when all FIFOs pop together. align_done and
  align_err are registered levels.
*/
`default_nettype none

module ca_align_ctrl
(
  input  logic                    com_clk,
  input  logic                    rst_com_n,
  input  logic                    rx_online,
  input  ca_cfg_pkg::rd_dly_t     rden_dly,
  input  ca_ctrl_pkg::lane_stat_t lane_stat,
  output logic                    lane_en,
  output logic                    fifo_pop,
  output logic                    align_done,
  output logic                    align_err
);

  import ca_cfg_pkg::*;
  import ca_ctrl_pkg::*;

  rx_state_e rx_state;
  rx_state_e rx_state_d;
  logic      rx_online_q;
  rd_dly_t   rd_dly;
  logic      all_started;
  logic      any_full;

  assign all_started = &lane_stat.started;
  assign any_full    = |lane_stat.full;

  //////////////////////////////
  // Read delay
  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      rx_online_q <= 1'b0;
      rd_dly      <= '0;
    end
    else
    begin
      rx_online_q <= rx_online;
      if (rx_online && !rx_online_q)
        rd_dly <= rden_dly;                  // Rising edge of rx_online
      else if (all_started && (rd_dly != '0))
        rd_dly <= rd_dly - rd_dly_t'(1);
    end
  end

  //////////////////////////////
  // Alignment FSM
  always_comb
  begin
    rx_state_d = rx_state;
    case (rx_state)
      RX_IDLE:
        if (rx_online)
          rx_state_d = RX_ONLINE;
      RX_ONLINE:
        if (any_full)
          rx_state_d = RX_ERR;               // Skew beyond FIFO depth
        else if (all_started)
          rx_state_d = (rd_dly == '0) ? RX_DONE : RX_ALIGNED;
      RX_ALIGNED:
        if (rd_dly == '0)
          rx_state_d = RX_DONE;
      RX_DONE, RX_ERR:
        rx_state_d = rx_state;
      default:
        rx_state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      rx_state   <= RX_IDLE;
      align_done <= 1'b0;
      align_err  <= 1'b0;
    end
    else
    begin
      rx_state   <= rx_state_d;
      align_done <= rx_state_d == RX_DONE;  // High with the first popped word
      align_err  <= rx_state == RX_ERR;
    end
  end

  assign lane_en  = (rx_state != RX_IDLE) && (rx_state != RX_ERR);
  assign fifo_pop = rx_state_d == RX_DONE;  // All started and delay expired

endmodule

`default_nettype wire

// File: hw/ca_lane_deskew.sv
/*
  Per-lane strobe detection and deskew FIFOs.
  Each lane starts writing at its strobe word and keeps writing every
  cycle. A common pop moves the head of every FIFO into the output
  register, so all lanes leave in step.
*/
`default_nettype none

module ca_lane_deskew
(
  input  logic                    com_clk,
  input  logic                    rst_com_n,
  input  ca_cfg_pkg::lane_bus_t   rx_din,
  input  ca_ctrl_pkg::stb_pos_t   stb_pos,
  input  logic                    lane_en,
  input  logic                    fifo_pop,
  output ca_ctrl_pkg::lane_stat_t lane_stat,
  output ca_cfg_pkg::lane_bus_t   rx_dout
);

  import ca_cfg_pkg::*;

  logic [NUM_CHANNELS-1:0] started_vec;
  logic [NUM_CHANNELS-1:0] full_vec;

  for (genvar l = 0; l < NUM_CHANNELS; l++)
  begin : g_lane
    chan_data_t                     lane_data;
    logic [NUM_WORDS*WORD_BITS-1:0] lane_pad;   // Unused slots read as zero
    logic [WORD_BITS-1:0]           stb_word;
    logic                           stb_hit;
    logic                           started;
    logic                           push;
    logic                           pop;
    chan_data_t                     mem [0:(1<<FIFO_AD_WIDTH)-1];
    logic [FIFO_AD_WIDTH-1:0]       wr_ptr;
    logic [FIFO_AD_WIDTH-1:0]       rd_ptr;
    logic [FIFO_AD_WIDTH:0]         count;
    chan_data_t                     dout_q;

    //////////////////////////////
    // Strobe detection
    assign lane_data = rx_din[l*BITS_PER_CHANNEL +: BITS_PER_CHANNEL];
    assign lane_pad  = {{(NUM_WORDS*WORD_BITS-BITS_PER_CHANNEL){1'b0}}, lane_data};
    assign stb_word  = lane_pad[stb_pos.word_idx*WORD_BITS +: WORD_BITS];
    assign stb_hit   = |(stb_word & stb_pos.bit_sel);

    always_ff @(posedge com_clk or negedge rst_com_n)
    begin
      if (!rst_com_n)
        started <= 1'b0;
      else if (lane_en && stb_hit)
        started <= 1'b1;  // Sticky until reset
    end

    //////////////////////////////
    // Deskew FIFO

    // Strobe word itself is written at the detecting edge
    assign push = lane_en && (started || stb_hit) && !count[FIFO_AD_WIDTH];
    assign pop  = fifo_pop && (count != '0);

    always_ff @(posedge com_clk or negedge rst_com_n)
    begin
      if (!rst_com_n)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end
      else
      begin
        if (push)
          wr_ptr <= wr_ptr + 1'b1;
        if (pop)
          rd_ptr <= rd_ptr + 1'b1;
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;    // Idle or push with pop
        endcase
      end
    end

    always_ff @(posedge com_clk)
    begin
      if (push)
        mem[wr_ptr] <= lane_data;
    end

    // Output word, held between pops
    always_ff @(posedge com_clk or negedge rst_com_n)
    begin
      if (!rst_com_n)
        dout_q <= '0;
      else if (pop)
        dout_q <= mem[rd_ptr];
    end

    assign rx_dout[l*BITS_PER_CHANNEL +: BITS_PER_CHANNEL] = dout_q;
    assign started_vec[l] = started;
    assign full_vec[l]    = count[FIFO_AD_WIDTH];  // Count of 8 means full
  end

  assign lane_stat.started = started_vec;
  assign lane_stat.full    = full_vec;

endmodule

`default_nettype wire

// File: hw/ca_stb_decode.sv
/*
  Strobe position decode.
  Turns the one-hot word and bit selects into a word index for the
  deskew stage and flags badly coded or out-of-range positions.
  Purely combinational, so the flags follow the selects directly.
*/
`default_nettype none

module ca_stb_decode
(
  input  ca_cfg_pkg::wd_sel_t   rx_stb_wd_sel,
  input  ca_cfg_pkg::bit_sel_t  rx_stb_bit_sel,
  output ca_ctrl_pkg::stb_pos_t stb_pos,
  output logic                  rx_stb_pos_err,
  output logic                  rx_stb_pos_coding_err
);

  import ca_cfg_pkg::*;

  word_idx_t                    word_idx;
  logic [$clog2(WORD_BITS)-1:0] bit_pos;
  stb_loc_t                     stb_loc;
  int                           wd_ones;
  int                           bit_ones;

  //////////////////////////////
  // Position lookup

  // Lowest set word bit wins
  always_comb
  begin
    word_idx = '0;
    for (int i = NUM_WORDS - 1; i >= 0; i--)
    begin
      if (rx_stb_wd_sel[i])
        word_idx = word_idx_t'(i);
    end
  end

  always_comb
  begin
    bit_pos = '0;
    for (int i = 0; i < WORD_BITS; i++)
    begin
      if (rx_stb_bit_sel[i])
        bit_pos = ($clog2(WORD_BITS))'(i);  // Highest set bit wins
    end
  end

  //////////////////////////////
  // Coding check
  always_comb
  begin
    wd_ones  = 0;
    bit_ones = 0;
    for (int i = 0; i < NUM_WORDS; i++)
      wd_ones = wd_ones + int'(rx_stb_wd_sel[i]);
    for (int i = 0; i < WORD_BITS; i++)
      bit_ones = bit_ones + int'(rx_stb_bit_sel[i]);
  end

  assign stb_loc = stb_loc_t'(word_idx * WORD_BITS) + stb_loc_t'(bit_pos);

  assign rx_stb_pos_err        = stb_loc > stb_loc_t'(BITS_PER_CHANNEL);
  assign rx_stb_pos_coding_err = (wd_ones != 1) || (bit_ones != 1);

  assign stb_pos.word_idx = word_idx;
  assign stb_pos.bit_sel  = rx_stb_bit_sel;

endmodule

`default_nettype wire

// File: hw/ca_ctrl_pkg.sv
/*
  Control types of the RX channel aligner.
  The alignment state encoding and the structs that pass between
  the decode, deskew and control stages.
*/
`default_nettype none

package ca_ctrl_pkg;

  import ca_cfg_pkg::*;

  // Alignment FSM states
  typedef enum logic [2:0] {
    RX_IDLE    = 3'd0,
    RX_ONLINE  = 3'd1,  // Waiting for every lane strobe
    RX_ALIGNED = 3'd2,  // Read delay running
    RX_DONE    = 3'd3,
    RX_ERR     = 3'd4   // Held until reset
  } rx_state_e;

  // Decoded strobe position for the deskew stage
  typedef struct packed {
    word_idx_t word_idx;
    bit_sel_t  bit_sel;
  } stb_pos_t;

  // Per-lane status toward control
  typedef struct packed {
    logic [NUM_CHANNELS-1:0] started;
    logic [NUM_CHANNELS-1:0] full;
  } lane_stat_t;

endpackage

`default_nettype wire

// File: hw/ca_cfg_pkg.sv
/*
  Lane and strobe field dimensions for the RX channel aligner.
  Holds the sizes shared by the decode, deskew and control stages
  and the vector types built from them.
*/
`default_nettype none

package ca_cfg_pkg;

  //////////////////////////////
  // Channel geometry
  localparam int NUM_CHANNELS     = 2;   // Lanes aligned together
  localparam int BITS_PER_CHANNEL = 80;
  localparam int WORD_BITS        = 40;  // One strobe word slot
  localparam int NUM_WORDS        = 8;
  localparam int FIFO_AD_WIDTH    = 3;   // Depth of 8 per lane

  //////////////////////////////
  // Vector types
  typedef logic [BITS_PER_CHANNEL-1:0]              chan_data_t;
  typedef logic [NUM_CHANNELS*BITS_PER_CHANNEL-1:0] lane_bus_t;  // Lane 0 in low bits
  typedef logic [NUM_WORDS-1:0]                     wd_sel_t;    // One-hot
  typedef logic [WORD_BITS-1:0]                     bit_sel_t;   // One-hot
  typedef logic [$clog2(NUM_WORDS)-1:0]             word_idx_t;
  typedef logic [$clog2(NUM_WORDS*WORD_BITS)-1:0]   stb_loc_t;
  typedef logic [2:0]                               rd_dly_t;

endpackage

`default_nettype wire
